/* quplsDecode.f */
quplsPkg.sv
quplsFifo.sv
quplsDecodeFc.sv
quplsDecodeStage.sv
quplsApbRegs.sv
quplsDecodeTop.sv
quplsDecodeSva.sv
quplsDecodeTb.sv

/* Makefile */
# Verilator build and run for the decoder front end

SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := quplsDecodeTb
FILELIST := quplsDecode.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Finished with errors" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* quplsDecodeTb.sv */
// ====================
// Decoder front end testbench
// Directed tests over the APB host port, every bundle read back is
// compared with a reference decoder built from the decode rules
// ====================
`timescale 1ns/1ps
`default_nettype none

module quplsDecodeTb;
	import quplsPkg::*;

	localparam int POLL_LIMIT  = 50;
	localparam int READY_LIMIT = 8;
	// Result queue, both pipeline slots and the instruction queue
	localparam int CAPACITY    = INSTR_DEPTH + RESULT_DEPTH + 2;

	logic                  clk = 1'b0;
	logic                  arstN;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [31:0]           pwdata;
	wire  [31:0]           prdata;
	wire                   pready;
	wire                   pslverr;

	int     errorCount = 0;
	int     checkCount = 0;
	integer seed = 65;

	// Opcodes that redirect the stream, then the rest including two unassigned codes
	logic [6:0] flowOps [12] = '{OP_CHK, OP_JSR, OP_JSRI, OP_DBRA, OP_BCC, OP_BCCU,
		OP_FBCCH, OP_FBCCS, OP_FBCCD, OP_FBCCQ, OP_BSR, OP_RTD};
	logic [6:0] plainOps [7] = '{OP_NOP, OP_ADD, OP_ADDI, OP_LOAD, OP_STORE, 7'd3, 7'd100};
	logic [6:0] allOps [$];
	// Bundles still expected from the result queue, oldest first
	logic [31:0] expQ [$];

	quplsDecodeTop DUT (
		.clk     (clk),
		.arstN   (arstN),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	always #5 clk = ~clk;

	// ====================
	// Checking and reference
	// ====================
	task automatic checkValue(input string testName, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("error %s: %s expected 0x%08h actual 0x%08h",
				testName, what, expected, actual);
		end
	endtask

	task automatic abortRun(input string reason);
		$display("%s at %0t ns", reason, $time);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount + 1);
		$display("Finished with errors");
		$finish;
	endtask

	// Expected bundle from the decode rules
	function automatic logic [31:0] refDecode(input logic [31:0] word);
		logic [6:0] op;
		logic [5:0] rd;
		logic [5:0] rs2;
		logic       condBr;
		logic       fc;
		logic       mem;
		logic       imm;
		op     = word[6:0];
		rd     = word[12:7];
		rs2    = word[24:19];
		condBr = op inside {OP_BCC, OP_BCCU, OP_FBCCH, OP_FBCCS, OP_FBCCD, OP_FBCCQ};
		fc     = condBr || (op inside {OP_CHK, OP_JSR, OP_JSRI, OP_DBRA, OP_BSR, OP_RTD});
		mem    = op inside {OP_LOAD, OP_STORE};
		// DBRA and BSR carry a displacement like the other branches
		imm    = condBr || (op inside {OP_ADDI, OP_LOAD, OP_STORE, OP_JSRI, OP_DBRA, OP_BSR});
		if (imm)
			rs2 = '0;
		if (condBr || (op == OP_STORE))
			rd = '0;
		return {4'b0000, imm, mem, fc, rs2, word[18:13], rd, op};
	endfunction

	function automatic logic [31:0] randomWord(input logic [6:0] op);
		logic [31:0] r;
		r = $random(seed);
		return {r[31:7], op};
	endfunction

	// ====================
	// APB host tasks
	// ====================
	task automatic apbAccess(input logic write, input logic [APB_ADDR_W-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waited;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		// Response is sampled mid-cycle, away from the clock edge
		@(negedge clk);
		waited = 0;
		while (!pready && waited < READY_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!pready)
			abortRun("APB transfer never completed because pready stayed low");
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apbWrite(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
		output logic err);
		logic [31:0] ignored;
		apbAccess(1'b1, addr, data, ignored, err);
	endtask

	task automatic apbRead(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic err);
		apbAccess(1'b0, addr, 32'h0, data, err);
	endtask

	task automatic writeInstr(input string testName, input logic [31:0] word);
		logic err;
		apbWrite(REG_INSTR, word, err);
		checkValue(testName, "instruction write pslverr", 32'h0, 32'(err));
	endtask

	// Polls STATUS until both counts match
	task automatic waitStatus(input int expInstr, input int expResult);
		logic [31:0] data;
		logic        err;
		int          polls;
		polls = 0;
		do
		begin
			apbRead(REG_STATUS, data, err);
			polls++;
		end
		while ((int'(data[STAT_INSTR_LSB +: COUNT_W]) != expInstr ||
			int'(data[STAT_RESULT_LSB +: COUNT_W]) != expResult) && polls < POLL_LIMIT);
		if (polls >= POLL_LIMIT)
			abortRun("STATUS never showed the expected queue counts");
	endtask

	// Waits for a bundle in the result queue, then pops it
	task automatic readResult(input string testName, output logic [31:0] data);
		logic [31:0] status;
		logic        err;
		int          polls;
		polls = 0;
		do
		begin
			apbRead(REG_STATUS, status, err);
			polls++;
		end
		while (status[STAT_RESULT_LSB +: COUNT_W] == '0 && polls < POLL_LIMIT);
		if (polls >= POLL_LIMIT)
			abortRun("no decoded bundle ever reached the result queue");
		apbRead(REG_RESULT, data, err);
		checkValue(testName, "result read pslverr", 32'h0, 32'(err));
	endtask

	task automatic drainExpected(input string testName);
		logic [31:0] data;
		while (expQ.size() > 0)
		begin
			readResult(testName, data);
			checkValue(testName, "bundle", expQ.pop_front(), data);
		end
	endtask

	// ====================
	// Tests
	// ====================
	task automatic testReset();
		logic [31:0] data;
		logic        err;
		@(negedge clk);
		checkValue("reset", "idle pslverr", 32'h0, 32'(pslverr));
		checkValue("reset", "idle prdata", 32'h0, prdata);
		apbRead(REG_STATUS, data, err);
		checkValue("reset", "STATUS", 32'h0, data);
		checkValue("reset", "STATUS pslverr", 32'h0, 32'(err));
		apbRead(REG_RESULT, data, err);
		checkValue("reset", "empty result data", 32'h0, data);
		checkValue("reset", "empty result pslverr", 32'h1, 32'(err));
	endtask

	task automatic testFlowCtrl();
		logic [31:0] data;
		foreach (flowOps[i])
		begin
			writeInstr("flowCtrl", randomWord(flowOps[i]));
			readResult("flowCtrl", data);
			checkValue("flowCtrl", "opcode", 32'(flowOps[i]), 32'(data[6:0]));
			checkValue("flowCtrl", "flowCtrl bit", 32'h1, 32'(data[25]));
		end
		foreach (plainOps[i])
		begin
			writeInstr("flowCtrl", randomWord(plainOps[i]));
			readResult("flowCtrl", data);
			checkValue("flowCtrl", "opcode", 32'(plainOps[i]), 32'(data[6:0]));
			checkValue("flowCtrl", "flowCtrl bit", 32'h0, 32'(data[25]));
		end
	endtask

	// Batches of four keep several words in flight at once
	task automatic testFieldDecode();
		logic [31:0] word;
		for (int round = 0; round < 2; round++)
		begin
			foreach (allOps[i])
			begin
				word = randomWord(allOps[i]);
				writeInstr("fieldDecode", word);
				expQ.push_back(refDecode(word));
				if (expQ.size() == 4)
					drainExpected("fieldDecode");
			end
		end
		drainExpected("fieldDecode");
	endtask

	task automatic testBackPressure();
		logic [31:0] word;
		logic        err;
		int          accepted;
		int          attempts;
		accepted = 0;
		attempts = 0;
		err      = 1'b0;
		// Nothing is read, so words pile up until the instruction queue is full
		while (!err && attempts < 2 * CAPACITY)
		begin
			word = randomWord(allOps[attempts % allOps.size()]);
			apbWrite(REG_INSTR, word, err);
			attempts++;
			if (!err)
			begin
				accepted++;
				expQ.push_back(refDecode(word));
			end
		end
		checkValue("backPressure", "accepted writes", CAPACITY, accepted);
		checkValue("backPressure", "overflow write pslverr", 32'h1, 32'(err));
		waitStatus(INSTR_DEPTH, RESULT_DEPTH);
		// Bundles must come back in write order with none lost
		drainExpected("backPressure");
		waitStatus(0, 0);
	endtask

	task automatic testStatusErrors();
		logic [31:0] word;
		logic [31:0] data;
		logic        err;
		repeat (2)
		begin
			word = randomWord(OP_ADD);
			writeInstr("statusErrors", word);
			expQ.push_back(refDecode(word));
		end
		waitStatus(0, 2);
		readResult("statusErrors", data);
		checkValue("statusErrors", "first bundle", expQ.pop_front(), data);
		apbRead(REG_STATUS, data, err);
		checkValue("statusErrors", "STATUS after one read", 32'(1) << STAT_RESULT_LSB, data);
		// Unmapped offset and wrong direction on mapped ones
		apbWrite(4'hC, randomWord(OP_ADD), err);
		checkValue("statusErrors", "unmapped write pslverr", 32'h1, 32'(err));
		apbRead(4'hC, data, err);
		checkValue("statusErrors", "unmapped read pslverr", 32'h1, 32'(err));
		checkValue("statusErrors", "unmapped read data", 32'h0, data);
		apbWrite(REG_STATUS, randomWord(OP_ADD), err);
		checkValue("statusErrors", "STATUS write pslverr", 32'h1, 32'(err));
		apbRead(REG_INSTR, data, err);
		checkValue("statusErrors", "INSTR read pslverr", 32'h1, 32'(err));
		apbRead(REG_STATUS, data, err);
		checkValue("statusErrors", "STATUS after bad accesses", 32'(1) << STAT_RESULT_LSB,
			data);
		drainExpected("statusErrors");
		waitStatus(0, 0);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial
	begin
		arstN   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		foreach (flowOps[i])
			allOps.push_back(flowOps[i]);
		foreach (plainOps[i])
			allOps.push_back(plainOps[i]);
		repeat (3) @(posedge clk);
		arstN <= 1'b1;
		testReset();
		testFlowCtrl();
		testFieldDecode();
		testBackPressure();
		testStatusErrors();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* quplsDecodeSva.sv */
// ====================
// Decoder front end assertions
// APB response rules and queue flag sanity, bound into the top level
// ====================
`timescale 1ns/1ps
`default_nettype none

module quplsDecodeSva (
	input wire clk,
	input wire arstN,
	input wire psel,
	input wire penable,
	input wire pready,
	input wire pslverr,
	input wire instrFull,
	input wire instrEmpty,
	input wire resultFull,
	input wire resultEmpty
);

	// The slave never inserts wait states
	apReadyHigh: assert property (@(posedge clk) disable iff (!arstN) pready)
		else $error("pready went low");

	// An error response only shows while a transfer is in its access phase
	apErrInAccess: assert property (@(posedge clk) disable iff (!arstN)
		pslverr |-> (psel && penable))
		else $error("pslverr high outside an access phase");

	// A queue can never be full and empty at once
	apInstrFlags: assert property (@(posedge clk) disable iff (!arstN)
		!(instrFull && instrEmpty))
		else $error("instruction queue reports full and empty together");

	apResultFlags: assert property (@(posedge clk) disable iff (!arstN)
		!(resultFull && resultEmpty))
		else $error("result queue reports full and empty together");

endmodule

bind quplsDecodeTop quplsDecodeSva uSva (
	.clk         (clk),
	.arstN       (arstN),
	.psel        (psel),
	.penable     (penable),
	.pready      (pready),
	.pslverr     (pslverr),
	.instrFull   (instrFull),
	.instrEmpty  (instrEmpty),
	.resultFull  (resultFull),
	.resultEmpty (resultEmpty)
);

`default_nettype wire

/* quplsDecodeTop.sv */
// ====================
// Decoder front end top level
// APB slave, instruction queue, two-slot decode pipeline and result queue
// With the host not reading, up to ten words are held in total
// ====================
`timescale 1ns/1ps
`default_nettype none

module quplsDecodeTop (
	input  wire                            clk,
	input  wire                            arstN,
	input  wire                            psel,
	input  wire                            penable,
	input  wire                            pwrite,
	input  wire [quplsPkg::APB_ADDR_W-1:0] paddr,
	input  wire [31:0]                     pwdata,
	output logic [31:0]                    prdata,
	output logic                           pready,
	output logic                           pslverr
);
	import quplsPkg::*;

	// Host side of the instruction queue
	logic               instrPush;
	instructionT        instrData;
	logic               instrFull;
	logic               instrEmpty;
	logic [COUNT_W-1:0] instrCount;

	// Queue head offered to the decode pipeline
	instructionT        instrWord;
	logic               instrReady;

	// Pipeline output and the result queue
	logic               outValid;
	decodedT            outBundle;
	logic               resultPop;
	decodedT            resultData;
	logic               resultFull;
	logic               resultEmpty;
	logic [COUNT_W-1:0] resultCount;

	quplsApbRegs uRegs (
		.clk         (clk),
		.arstN       (arstN),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.instrFull   (instrFull),
		.resultEmpty (resultEmpty),
		.resultData  (resultData),
		.instrCount  (instrCount),
		.resultCount (resultCount),
		.instrPush   (instrPush),
		.instrData   (instrData),
		.resultPop   (resultPop)
	);

	// Pop follows ready since the FIFO ignores a pop while empty
	quplsFifo #(.payloadT(instructionT), .DEPTH(INSTR_DEPTH)) uInstrQ (
		.clk      (clk),
		.arstN    (arstN),
		.push     (instrPush),
		.pushData (instrData),
		.pop      (instrReady),
		.popData  (instrWord),
		.full     (instrFull),
		.empty    (instrEmpty),
		.count    (instrCount)
	);

	quplsDecodeStage uDecode (
		.clk        (clk),
		.arstN      (arstN),
		.instrValid (!instrEmpty),
		.instrWord  (instrWord),
		.instrReady (instrReady),
		.outValid   (outValid),
		.outBundle  (outBundle),
		.outReady   (!resultFull)
	);

	// A bundle moves only when slot two sees ready, so a held bundle is never pushed twice
	quplsFifo #(.payloadT(decodedT), .DEPTH(RESULT_DEPTH)) uResultQ (
		.clk      (clk),
		.arstN    (arstN),
		.push     (outValid && !resultFull),
		.pushData (outBundle),
		.pop      (resultPop),
		.popData  (resultData),
		.full     (resultFull),
		.empty    (resultEmpty),
		.count    (resultCount)
	);

endmodule

`default_nettype wire

/* quplsApbRegs.sv */
// ====================
// APB register slave
// Instruction writes push the instruction queue, result reads pop
// the result queue, STATUS shows both counts, no wait states
// ====================
`timescale 1ns/1ps
`default_nettype none

module quplsApbRegs (
	input  wire                                 clk,
	input  wire                                 arstN,
	input  wire                                 psel,
	input  wire                                 penable,
	input  wire                                 pwrite,
	input  wire [quplsPkg::APB_ADDR_W-1:0]      paddr,
	input  wire [31:0]                          pwdata,
	output logic [31:0]                         prdata,
	output logic                                pready,
	output logic                                pslverr,
	input  wire                                 instrFull,
	input  wire                                 resultEmpty,
	input  wire quplsPkg::decodedT              resultData,
	input  wire [quplsPkg::COUNT_W-1:0]         instrCount,
	input  wire [quplsPkg::COUNT_W-1:0]         resultCount,
	output logic                                instrPush,
	output quplsPkg::instructionT               instrData,
	output logic                                resultPop
);
	import quplsPkg::*;

	logic        setupPhase;
	logic        accessPhase;
	logic [31:0] statusWord;
	logic [31:0] nextRdata;
	logic        nextErr;

	assign setupPhase  = psel && !penable;
	assign accessPhase = psel && penable;
	assign pready      = 1'b1;

	always_comb
	begin
		statusWord = '0;
		statusWord[STAT_INSTR_LSB +: COUNT_W]  = instrCount;
		statusWord[STAT_RESULT_LSB +: COUNT_W] = resultCount;
	end

	// ====================
	// Response decode
	// ====================
	// Worked out during setup so the response is stable for the whole access cycle
	always_comb
	begin
		nextRdata = '0;
		nextErr   = 1'b1;
		case (paddr)
			REG_INSTR:
			begin
				// Write only, a full queue rejects the word
				if (pwrite)
					nextErr = instrFull;
			end
			REG_RESULT:
			begin
				if (!pwrite)
				begin
					nextErr   = resultEmpty;
					nextRdata = resultEmpty ? '0 : 32'(resultData);
				end
			end
			REG_STATUS:
			begin
				if (!pwrite)
				begin
					nextErr   = 1'b0;
					nextRdata = statusWord;
				end
			end
			default:
				nextErr = 1'b1;
		endcase
	end

	// Response registers are driven only during the access cycle
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			prdata  <= '0;
			pslverr <= 1'b0;
		end
		else if (setupPhase)
		begin
			prdata  <= nextRdata;
			pslverr <= nextErr;
		end
		else
		begin
			prdata  <= '0;
			pslverr <= 1'b0;
		end
	end

	// Queue side effects happen in the access cycle unless it reports an error
	assign instrPush = accessPhase && pwrite && (paddr == REG_INSTR) && !pslverr;
	assign instrData = pwdata;
	assign resultPop = accessPhase && !pwrite && (paddr == REG_RESULT) && !pslverr;

endmodule

`default_nettype wire

/* quplsDecodeStage.sv */
// ====================
// Two-slot decode pipeline
// Slot one captures the raw fields and the flow-control flag,
// slot two adds the derived flags and presents the finished bundle
// ====================
`timescale 1ns/1ps
`default_nettype none

module quplsDecodeStage (
	input  wire                        clk,
	input  wire                        arstN,
	input  wire                        instrValid,
	input  wire quplsPkg::instructionT instrWord,
	output logic                       instrReady,
	output logic                       outValid,
	output quplsPkg::decodedT          outBundle,
	input  wire                        outReady
);
	import quplsPkg::*;

	logic             fcFlag;
	logic             s1Valid;
	opcodeT           s1Opcode;
	logic [REG_W-1:0] s1Rd;
	logic [REG_W-1:0] s1Rs1;
	logic [REG_W-1:0] s1Rs2;
	logic             s1Flow;
	logic             s2Free;
	logic             isMem;
	logic             hasImm;
	logic             noDest;
	decodedT          nextBundle;

	quplsDecodeFc uFc (
		.instr    (instrWord),
		.flowCtrl (fcFlag)
	);

	// ====================
	// Handshake
	// ====================
	// Slot two can take a new bundle when empty or when its bundle leaves now
	assign s2Free     = !outValid || outReady;
	// Slot one accepts when empty or when it moves into slot two this cycle
	assign instrReady = !s1Valid || s2Free;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			s1Valid  <= 1'b0;
			outValid <= 1'b0;
		end
		else
		begin
			if (instrReady)
				s1Valid <= instrValid;
			if (s2Free)
				outValid <= s1Valid;
		end
	end

	// Slot one payload, raw fields straight from the word
	always_ff @(posedge clk)
	begin
		if (instrReady && instrValid)
		begin
			s1Opcode <= opcodeT'(instrWord[OPC_LSB +: OPC_W]);
			s1Rd     <= instrWord[RD_LSB +: REG_W];
			s1Rs1    <= instrWord[RS1_LSB +: REG_W];
			s1Rs2    <= instrWord[RS2_LSB +: REG_W];
			s1Flow   <= fcFlag;
		end
	end

	// ====================
	// Derived fields
	// ====================
	always_comb
	begin
		isMem  = (s1Opcode == OP_LOAD) || (s1Opcode == OP_STORE);
		// Immediate forms carry low immediate bits where rs2 would sit
		// DBRA and BSR count as branch forms here
		case (s1Opcode)
			OP_ADDI, OP_LOAD, OP_STORE, OP_JSRI, OP_DBRA, OP_BSR,
			OP_BCC, OP_BCCU, OP_FBCCH, OP_FBCCS, OP_FBCCD, OP_FBCCQ:
				hasImm = 1'b1;
			default:
				hasImm = 1'b0;
		endcase
		// Stores and conditional branches write no register
		// DBRA keeps rd since it writes back the decremented counter
		case (s1Opcode)
			OP_STORE, OP_BCC, OP_BCCU, OP_FBCCH, OP_FBCCS, OP_FBCCD, OP_FBCCQ:
				noDest = 1'b1;
			default:
				noDest = 1'b0;
		endcase
		nextBundle.pad      = '0;
		nextBundle.hasImm   = hasImm;
		nextBundle.isMem    = isMem;
		nextBundle.flowCtrl = s1Flow;
		nextBundle.rs2      = hasImm ? '0 : s1Rs2;
		nextBundle.rs1      = s1Rs1;
		nextBundle.rd       = noDest ? '0 : s1Rd;
		nextBundle.opcode   = s1Opcode;
	end

	// Slot two payload, held while the result queue is full
	always_ff @(posedge clk)
	begin
		if (s2Free && s1Valid)
			outBundle <= nextBundle;
	end

endmodule

`default_nettype wire

/* quplsDecodeFc.sv */
// ====================
// Flow-control detector
// Flags opcodes that can redirect the instruction stream
// ====================
`timescale 1ns/1ps
`default_nettype none

module quplsDecodeFc (
	input  wire quplsPkg::instructionT instr,
	output logic                       flowCtrl
);
	import quplsPkg::*;

	// Checks, subroutine jumps, every branch form and returns all count
	function automatic logic fnIsFlowCtrl(input opcodeT op);
		logic isFc;
		isFc = 1'b0;
		case (op)
			OP_CHK:
				isFc = 1'b1;
			OP_JSR, OP_JSRI:
				isFc = 1'b1;
			// Counted loop branch plus the integer and float conditional branches
			OP_DBRA, OP_BCC, OP_BCCU,
			OP_FBCCH, OP_FBCCS, OP_FBCCD, OP_FBCCQ:
				isFc = 1'b1;
			OP_BSR, OP_RTD:
				isFc = 1'b1;
			default:
				isFc = 1'b0;
		endcase
		return isFc;
	endfunction

	assign flowCtrl = fnIsFlowCtrl(opcodeT'(instr[OPC_LSB +: OPC_W]));

endmodule

`default_nettype wire

/* quplsFifo.sv */
// ====================
// Synchronous FIFO
// Circular buffer for any payload type, head entry shown on popData,
// occupancy reported as a count with full and empty flags
// ====================
`timescale 1ns/1ps
`default_nettype none

module quplsFifo #(
	parameter type payloadT = logic [31:0],
	parameter int  DEPTH    = 4
)(
	input  wire                            clk,
	input  wire                            arstN,
	input  wire                            push,
	input  wire payloadT                   pushData,
	input  wire                            pop,
	output payloadT                        popData,
	output logic                           full,
	output logic                           empty,
	output logic [quplsPkg::COUNT_W-1:0]   count
);
	import quplsPkg::*;

	// Storage has no reset, only the pointers and the count are control state
	payloadT mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] rdPtr;
	logic [$clog2(DEPTH)-1:0] wrPtr;
	logic doPush;
	logic doPop;

	assign full  = (count == COUNT_W'(DEPTH));
	assign empty = (count == '0);

	// A pop frees a slot in the same cycle, so push is legal when full and popping
	assign doPush = push && (!full || pop);
	assign doPop  = pop && !empty;

	assign popData = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap explicitly so depths other than a power of two work
			if (doPush)
				wrPtr <= (int'(wrPtr) == DEPTH - 1) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (int'(rdPtr) == DEPTH - 1) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* quplsPkg.sv */
// ====================
// Decoder front-end package
// Opcodes, instruction field positions, the decoded bundle layout,
// the APB register map and the queue sizes shared by every block
// ====================
`default_nettype none

package quplsPkg;

	// Raw 32-bit instruction word as written by the host
	typedef logic [31:0] instructionT;

	// Field positions inside an instruction word
	localparam int OPC_LSB = 0;
	localparam int OPC_W   = 7;
	localparam int RD_LSB  = 7;
	localparam int RS1_LSB = 13;
	localparam int RS2_LSB = 19;
	// All three register fields share one width
	localparam int REG_W   = 6;

	// Opcodes known to the decoder, all others decode as plain ALU forms
	typedef enum logic [6:0] {
		OP_NOP   = 7'd0,
		OP_ADD   = 7'd2,
		OP_ADDI  = 7'd4,
		OP_LOAD  = 7'd8,
		OP_STORE = 7'd9,
		OP_CHK   = 7'd16,
		OP_JSR   = 7'd17,
		OP_JSRI  = 7'd18,
		OP_DBRA  = 7'd19,
		OP_BCC   = 7'd20,
		OP_BCCU  = 7'd21,
		OP_FBCCH = 7'd22,
		OP_FBCCS = 7'd23,
		OP_FBCCD = 7'd24,
		OP_FBCCQ = 7'd25,
		OP_BSR   = 7'd26,
		OP_RTD   = 7'd27
	} opcodeT;

	// Decoded bundle, 32 bits, first member is the most significant
	typedef struct packed {
		logic [3:0]       pad;
		logic             hasImm;
		logic             isMem;
		logic             flowCtrl;
		logic [REG_W-1:0] rs2;
		logic [REG_W-1:0] rs1;
		logic [REG_W-1:0] rd;
		opcodeT           opcode;
	} decodedT;

	// ====================
	// Queues and host register map
	// ====================
	localparam int INSTR_DEPTH  = 4;
	localparam int RESULT_DEPTH = 4;
	// Wide enough to hold a count equal to the depth
	localparam int COUNT_W      = 3;

	localparam int APB_ADDR_W = 4;
	localparam logic [APB_ADDR_W-1:0] REG_INSTR  = 4'h0;
	localparam logic [APB_ADDR_W-1:0] REG_RESULT = 4'h4;
	localparam logic [APB_ADDR_W-1:0] REG_STATUS = 4'h8;

	// Where each count sits in the STATUS word
	localparam int STAT_INSTR_LSB  = 0;
	localparam int STAT_RESULT_LSB = 8;

endpackage

`default_nettype wire
